// ==== include/useq_cfg.svh ====
//////////////////////////////
// Micro-sequencer widths
// Address, tag and return stack sizing
//////////////////////////////

`ifndef USEQ_CFG_SVH
`define USEQ_CFG_SVH

// Micro-address width
`define USEQ_UADDR_W 14

// Tag saved with each return address
`define USEQ_TAG_W 5

// Stack entry, tag above address
`define USEQ_SPC_W (`USEQ_TAG_W + `USEQ_UADDR_W)

// Return stack entries
`define USEQ_SPC_DEPTH 32

// Stack pointer, wraps at depth
`define USEQ_PTR_W 5

`endif

// ==== src/useq_pkg.sv ====
//////////////////////////////
// Micro-sequencer types
// Phase and jump operation encodings
//////////////////////////////

package useq_pkg;

   // One microinstruction spans four phases
   typedef enum logic [1:0] {
      PH_DECODE = 2'd0,
      PH_READ   = 2'd1,
      PH_WRITE  = 2'd2,
      PH_FETCH  = 2'd3
   } phase_t;

   // Next-address operation
   // Call and return use the stack
   typedef enum logic [1:0] {
      OP_NEXT   = 2'd0,
      OP_JUMP   = 2'd1,
      OP_CALL   = 2'd2,
      OP_RETURN = 2'd3
   } jump_op_t;

endpackage

// ==== src/useq_phase.sv ====
//////////////////////////////
// Phase generator
// Cycles decode, read, write, fetch
//////////////////////////////

`timescale 1ns/1ps

module useq_phase (
   input  logic              clk,
   input  logic              reset,
   output useq_pkg::phase_t  phase,
   output logic              fetch
);

   import useq_pkg::*;

   //////////////////////////////
   // Phase state
   //////////////////////////////

   // One step per clock, no stalls
   always_ff @(posedge clk) begin
      if (reset) begin
         phase <= PH_DECODE;
      end else begin
         case (phase)
            PH_DECODE: phase <= PH_READ;
            PH_READ:   phase <= PH_WRITE;
            PH_WRITE:  phase <= PH_FETCH;
            default:   phase <= PH_DECODE;
         endcase
      end
   end

   // Fetch level, whole cycle
   assign fetch = (phase == PH_FETCH);

   // Never skips or repeats a phase out of reset
   a_phase_step : assert property (
      @(posedge clk) disable iff (reset)
      1'b1 |=> (phase == phase_t'($past(phase) + 2'd1))
   ) else $error("phase did not advance to its successor");

endmodule

// ==== src/spc_stack.sv ====
//////////////////////////////
// Subroutine return stack
// 32-entry RAM, registered read,
// pointer moved in fetch phase
//////////////////////////////

`timescale 1ns/1ps

`include "useq_cfg.svh"

module spc_stack (
   input  logic                     clk,
   input  logic                     reset,
   input  useq_pkg::phase_t         phase,
   input  logic [`USEQ_SPC_W-1:0]   spcw,
   input  logic                     spcnt,
   input  logic                     spush,
   input  logic                     srp,
   input  logic                     swp,
   output logic [`USEQ_SPC_W-1:0]   spco,
   output logic [`USEQ_PTR_W-1:0]   spc_ptr
);

   import useq_pkg::*;

   // Storage, tag in the top bits
   logic [`USEQ_SPC_W-1:0] ram [`USEQ_SPC_DEPTH];

   // Pointer plus one, also the push slot
   logic [`USEQ_PTR_W-1:0] ptr_inc;
   // Slot actually written
   logic [`USEQ_PTR_W-1:0] wr_addr;

   //////////////////////////////
   // Write side
   //////////////////////////////

   assign ptr_inc = spc_ptr + `USEQ_PTR_W'(1);

   // Push lands one above the top, pointer catches up in fetch
   assign wr_addr = (spcnt && spush) ? ptr_inc : spc_ptr;

   always_ff @(posedge clk) begin
      if (swp) begin
         ram[wr_addr] <= spcw;
      end
   end

   //////////////////////////////
   // Read side
   //////////////////////////////

   // Top of stack captured on the read strobe
   // Read and write sit in different phases, so no bypass
   always_ff @(posedge clk) begin
      if (reset) begin
         spco <= '0;
      end else if (srp) begin
         spco <= ram[spc_ptr];
      end
   end

   //////////////////////////////
   // Stack pointer
   //////////////////////////////

   // Wraps modulo depth, overflow goes unnoticed
   always_ff @(posedge clk) begin
      if (reset) begin
         spc_ptr <= '0;
      end else if (phase == PH_FETCH && spcnt) begin
         if (spush) begin
            spc_ptr <= ptr_inc;
         end else begin
            spc_ptr <= spc_ptr - `USEQ_PTR_W'(1);
         end
      end
   end

   // Pointer only moves at the edge closing fetch
   a_ptr_fetch_only : assert property (
      @(posedge clk) disable iff (reset)
      (!$past(reset) && spc_ptr != $past(spc_ptr)) |-> ($past(phase) == PH_FETCH)
   ) else $error("stack pointer moved outside fetch");

endmodule

// ==== src/upc_next.sv ====
//////////////////////////////
// Next micro-address logic
// Latches the instruction, drives
// stack strobes, updates upc
//////////////////////////////

`timescale 1ns/1ps

`include "useq_cfg.svh"

module upc_next (
   input  logic                      clk,
   input  logic                      reset,
   input  useq_pkg::phase_t          phase,
   input  useq_pkg::jump_op_t        op,
   input  logic [`USEQ_UADDR_W-1:0]  target,
   input  logic                      cond,
   input  logic [`USEQ_TAG_W-1:0]    call_tag,
   input  logic [`USEQ_SPC_W-1:0]    spco,
   output logic                      srp,
   output logic                      swp,
   output logic                      spcnt,
   output logic                      spush,
   output logic [`USEQ_SPC_W-1:0]    spcw,
   output logic [`USEQ_UADDR_W-1:0]  upc,
   output logic [`USEQ_TAG_W-1:0]    ret_tag
);

   import useq_pkg::*;

   // Latched instruction
   jump_op_t                  op_q;
   logic                      taken_q;
   logic [`USEQ_UADDR_W-1:0]  target_q;
   logic [`USEQ_TAG_W-1:0]    tag_q;

   // Decoded stack activity
   logic                      do_call;
   logic                      do_ret;
   // Sequential address, also the return address
   logic [`USEQ_UADDR_W-1:0]  upc_inc;

   //////////////////////////////
   // Instruction latch
   //////////////////////////////

   // Next always counts as taken
   always_ff @(posedge clk) begin
      if (reset) begin
         op_q    <= OP_NEXT;
         taken_q <= 1'b0;
      end else if (phase == PH_DECODE) begin
         op_q    <= op;
         taken_q <= cond || (op == OP_NEXT);
      end
   end

   // Operand fields
   always_ff @(posedge clk) begin
      if (phase == PH_DECODE) begin
         target_q <= target;
         tag_q    <= call_tag;
      end
   end

   //////////////////////////////
   // Stack strobes
   //////////////////////////////

   assign do_call = taken_q && (op_q == OP_CALL);
   assign do_ret  = taken_q && (op_q == OP_RETURN);

   // Read in read phase, write in write phase
   assign srp   = do_ret && (phase == PH_READ);
   assign swp   = do_call && (phase == PH_WRITE);
   // Held read through fetch so the push slot stays put
   assign spcnt = (do_call || do_ret) && (phase != PH_DECODE);
   assign spush = (op_q == OP_CALL);

   assign upc_inc = upc + `USEQ_UADDR_W'(1);
   // Pushed entry is tag then return address
   assign spcw    = {tag_q, upc_inc};

   //////////////////////////////
   // Micro-address update
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         upc     <= '0;
         ret_tag <= '0;
      end else if (phase == PH_FETCH) begin
         if (!taken_q) begin
            upc <= upc_inc;
         end else begin
            case (op_q)
               OP_JUMP, OP_CALL: upc <= target_q;
               OP_RETURN: begin
                  // spco loaded at end of read
                  upc     <= spco[`USEQ_UADDR_W-1:0];
                  ret_tag <= spco[`USEQ_SPC_W-1:`USEQ_UADDR_W];
               end
               default: upc <= upc_inc;
            endcase
         end
      end
   end

   // One stack port use per instruction
   a_no_rw_overlap : assert property (
      @(posedge clk) disable iff (reset)
      !(srp && swp)
   ) else $error("stack read and write strobes overlap");

endmodule

// ==== src/useq_top.sv ====
//////////////////////////////
// Micro-sequencer top
// Phases, next address, return stack
//////////////////////////////

`timescale 1ns/1ps

`include "useq_cfg.svh"

module useq_top (
   input  logic                      clk,
   input  logic                      reset,
   input  useq_pkg::jump_op_t        op,
   input  logic [`USEQ_UADDR_W-1:0]  target,
   input  logic                      cond,
   input  logic [`USEQ_TAG_W-1:0]    call_tag,
   output logic [`USEQ_UADDR_W-1:0]  upc,
   output logic [`USEQ_TAG_W-1:0]    ret_tag,
   output logic [`USEQ_PTR_W-1:0]    spc_ptr,
   output logic                      fetch
);

   import useq_pkg::*;

   // Current phase, shared
   phase_t                    phase;

   // Stack control and data
   logic                      srp;
   logic                      swp;
   logic                      spcnt;
   logic                      spush;
   logic [`USEQ_SPC_W-1:0]    spcw;
   logic [`USEQ_SPC_W-1:0]    spco;

   //////////////////////////////
   // Blocks
   //////////////////////////////

   useq_phase u_phase (
      .clk   (clk),
      .reset (reset),
      .phase (phase),
      .fetch (fetch)
   );

   upc_next u_next (
      .clk      (clk),
      .reset    (reset),
      .phase    (phase),
      .op       (op),
      .target   (target),
      .cond     (cond),
      .call_tag (call_tag),
      .spco     (spco),
      .srp      (srp),
      .swp      (swp),
      .spcnt    (spcnt),
      .spush    (spush),
      .spcw     (spcw),
      .upc      (upc),
      .ret_tag  (ret_tag)
   );

   // Return addresses live here
   spc_stack u_stack (
      .clk     (clk),
      .reset   (reset),
      .phase   (phase),
      .spcw    (spcw),
      .spcnt   (spcnt),
      .spush   (spush),
      .srp     (srp),
      .swp     (swp),
      .spco    (spco),
      .spc_ptr (spc_ptr)
   );

endmodule

// ==== sim/useq_clkgen.sv ====
//////////////////////////////
// Testbench clock
// Free-running, 20 ns period
//////////////////////////////

`timescale 1ns/1ps

module useq_clkgen (
   output logic clk
);

   // Low first, rising edges at 10, 30, 50 ns
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

endmodule

// ==== sim/useq_tb.sv ====
//////////////////////////////
// Micro-sequencer testbench
// Directed and random microinstructions
// checked against a model of upc and stack
//////////////////////////////

`timescale 1ns/1ps

`include "useq_cfg.svh"

module useq_tb;

   import useq_pkg::*;

   // One issued microinstruction
   typedef struct packed {
      jump_op_t                  op;
      logic [`USEQ_UADDR_W-1:0]  target;
      logic                      cond;
      logic [`USEQ_TAG_W-1:0]    tag;
   } instr_t;

   // Model result packs upc, tag, pointer
   localparam int RES_W      = `USEQ_UADDR_W + `USEQ_TAG_W + `USEQ_PTR_W;
   // Cycles allowed for any single wait
   localparam int WAIT_LIMIT = 8;

   logic                      clk;
   logic                      reset;
   jump_op_t                  op;
   logic [`USEQ_UADDR_W-1:0]  target;
   logic                      cond;
   logic [`USEQ_TAG_W-1:0]    call_tag;
   logic [`USEQ_UADDR_W-1:0]  upc;
   logic [`USEQ_TAG_W-1:0]    ret_tag;
   logic [`USEQ_PTR_W-1:0]    spc_ptr;
   logic                      fetch;

   // Model of stack and sequencer state
   logic [`USEQ_SPC_W-1:0]    model_stack [`USEQ_SPC_DEPTH];
   logic [`USEQ_UADDR_W-1:0]  model_upc;
   logic [`USEQ_TAG_W-1:0]    model_tag;
   logic [`USEQ_PTR_W-1:0]    model_ptr;

   // Issued but not yet compared
   instr_t                    pending [$];
   int                        issued;
   int                        checked;
   integer                    seed;

   // Rising edges since reset release
   int                        edges;
   logic                      armed;

   useq_clkgen u_clkgen (
      .clk (clk)
   );

   useq_top u_useq_top (
      .clk      (clk),
      .reset    (reset),
      .op       (op),
      .target   (target),
      .cond     (cond),
      .call_tag (call_tag),
      .upc      (upc),
      .ret_tag  (ret_tag),
      .spc_ptr  (spc_ptr),
      .fetch    (fetch)
   );

   //////////////////////////////
   // Reporting
   //////////////////////////////

   task automatic stop_with_failure();
      $display("Done: errors found");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic fail_timeout(input string what);
      $display("Timeout: no %s within %0d cycles", what, WAIT_LIMIT);
      stop_with_failure();
   endtask

   //////////////////////////////
   // Reference model
   //////////////////////////////

   // Next upc, ret_tag, pointer for one instruction
   function automatic logic [RES_W-1:0] ref_next(
      input instr_t                    ins,
      input logic [`USEQ_UADDR_W-1:0]  cur_upc,
      input logic [`USEQ_TAG_W-1:0]    cur_tag,
      input logic [`USEQ_PTR_W-1:0]    cur_ptr
   );
      logic                      taken;
      logic [`USEQ_UADDR_W-1:0]  n_upc;
      logic [`USEQ_TAG_W-1:0]    n_tag;
      logic [`USEQ_PTR_W-1:0]    n_ptr;
      logic [`USEQ_SPC_W-1:0]    top;

      // Next is taken whatever cond says
      taken = ins.cond || (ins.op == OP_NEXT);
      n_upc = cur_upc + `USEQ_UADDR_W'(1);
      n_tag = cur_tag;
      n_ptr = cur_ptr;
      top   = model_stack[cur_ptr];
      if (taken) begin
         case (ins.op)
            OP_JUMP: n_upc = ins.target;
            OP_CALL: begin
               n_upc = ins.target;
               n_ptr = cur_ptr + `USEQ_PTR_W'(1);
            end
            OP_RETURN: begin
               // Pop from the entry under the pointer
               n_upc = top[`USEQ_UADDR_W-1:0];
               n_tag = top[`USEQ_SPC_W-1:`USEQ_UADDR_W];
               n_ptr = cur_ptr - `USEQ_PTR_W'(1);
            end
            default: n_upc = cur_upc + `USEQ_UADDR_W'(1);
         endcase
      end
      return {n_upc, n_tag, n_ptr};
   endfunction

   // Random mix with three in eight calls and three in eight returns
   function automatic jump_op_t pick_op(input logic [2:0] sel);
      jump_op_t sel_op;

      case (sel)
         3'd0:             sel_op = OP_NEXT;
         3'd1:             sel_op = OP_JUMP;
         3'd2, 3'd3, 3'd4: sel_op = OP_CALL;
         default:          sel_op = OP_RETURN;
      endcase
      return sel_op;
   endfunction

   //////////////////////////////
   // Driver
   //////////////////////////////

   // Called at a decode-phase falling edge and returns at the next one
   task automatic issue(input jump_op_t new_op, input logic [`USEQ_UADDR_W-1:0] new_target,
                        input logic new_cond, input logic [`USEQ_TAG_W-1:0] new_tag);
      instr_t ins;
      int     waited;

      op       = new_op;
      target   = new_target;
      cond     = new_cond;
      call_tag = new_tag;
      ins.op     = new_op;
      ins.target = new_target;
      ins.cond   = new_cond;
      ins.tag    = new_tag;
      pending.push_back(ins);
      issued++;
      waited = 0;
      @(negedge clk);
      while (!fetch && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!fetch) fail_timeout("fetch phase after issue");
      // Falling edge of the following decode cycle
      @(negedge clk);
   endtask

   //////////////////////////////
   // Fetch cadence monitor
   //////////////////////////////

   always @(posedge clk) begin
      if (reset) begin
         edges <= 0;
         armed <= 1'b0;
      end else begin
         edges <= edges + 1;
         armed <= 1'b1;
      end
   end

   // Fetch after every third, seventh, ... edge
   always @(negedge clk) begin
      if (armed) begin
         check_value("fetch", 32'(fetch), 32'((edges % 4) == 3));
      end
   end

   //////////////////////////////
   // Compare process
   //////////////////////////////

   initial begin : compare
      instr_t            ins;
      logic [RES_W-1:0]  res;
      int                waited;

      waited = 0;
      @(posedge clk);
      while (reset && waited < WAIT_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      if (reset) fail_timeout("reset release");
      forever begin
         waited = 0;
         @(negedge clk);
         while (!fetch && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
         end
         if (!fetch) fail_timeout("fetch phase at compare");
         // Outputs settle at the edge closing fetch
         @(posedge clk);
         @(negedge clk);
         if (pending.size() > 0) begin
            ins = pending.pop_front();
            res = ref_next(ins, model_upc, model_tag, model_ptr);
            // Taken call pushes tag and return address
            if (ins.op == OP_CALL && ins.cond) begin
               model_stack[model_ptr + `USEQ_PTR_W'(1)] =
                  {ins.tag, model_upc + `USEQ_UADDR_W'(1)};
            end
            {model_upc, model_tag, model_ptr} = res;
            check_value("upc", 32'(upc), 32'(model_upc));
            check_value("ret_tag", 32'(ret_tag), 32'(model_tag));
            check_value("spc_ptr", 32'(spc_ptr), 32'(model_ptr));
            checked++;
         end
      end
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   initial begin : stimulus
      logic [31:0]  rnd;
      jump_op_t     sel;
      int           i;
      int           waited;

      seed      = 51;
      reset     = 1'b1;
      op        = OP_NEXT;
      target    = '0;
      cond      = 1'b0;
      call_tag  = '0;
      model_upc = '0;
      model_tag = '0;
      model_ptr = '0;
      issued    = 0;
      checked   = 0;

      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // Cleared state in the decode phase
      check_value("upc after reset", 32'(upc), 32'd0);
      check_value("ret_tag after reset", 32'(ret_tag), 32'd0);
      check_value("spc_ptr after reset", 32'(spc_ptr), 32'd0);
      check_value("fetch after reset", 32'(fetch), 32'd0);

      // Next plus branches with cond low
      for (i = 0; i < 12; i++) begin
         rnd = $random(seed);
         sel = jump_op_t'(rnd[1:0]);
         issue(sel, rnd[15:2], (sel == OP_NEXT) ? rnd[16] : 1'b0, rnd[21:17]);
      end

      // Jump near the top then step across the wrap
      issue(OP_JUMP, {{(`USEQ_UADDR_W-1){1'b1}}, 1'b0}, 1'b1, '0);
      issue(OP_NEXT, '0, 1'b0, '0);
      issue(OP_NEXT, '0, 1'b1, '0);
      for (i = 0; i < 6; i++) begin
         rnd = $random(seed);
         issue(OP_JUMP, rnd[13:0], 1'b1, rnd[18:14]);
      end

      // Nested calls then unwind
      for (i = 0; i < 6; i++) begin
         rnd = $random(seed);
         issue(OP_CALL, rnd[13:0], 1'b1, rnd[18:14]);
         issue(OP_NEXT, '0, 1'b0, '0);
      end
      for (i = 0; i < 6; i++) begin
         issue(OP_RETURN, '0, 1'b1, '0);
         issue(OP_NEXT, '0, 1'b0, '0);
      end

      // Overfill so the pointer wraps and entries get overwritten
      for (i = 0; i < 40; i++) begin
         rnd = $random(seed);
         issue(OP_CALL, rnd[13:0], 1'b1, rnd[18:14]);
      end
      for (i = 0; i < 40; i++) begin
         issue(OP_RETURN, '0, 1'b1, '0);
      end

      // Long random run with cond high three times in four
      for (i = 0; i < 400; i++) begin
         rnd = $random(seed);
         issue(pick_op(rnd[2:0]), rnd[18:5], (rnd[4:3] != 2'b00), rnd[23:19]);
      end

      waited = 0;
      while (checked < issued && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (checked == issued) begin
         $display("Done: no errors");
         $finish;
      end else begin
         $display("Timeout: compare process did not check every instruction");
         stop_with_failure();
      end
   end

endmodule

// ==== flist.f ====
+incdir+include
src/useq_pkg.sv
src/useq_phase.sv
src/spc_stack.sv
src/upc_next.sv
src/useq_top.sv
sim/useq_clkgen.sv
sim/useq_tb.sv

// ==== Makefile ====
# Verilator flow for the micro-sequencer testbench

TOP := useq_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o V$(TOP)

# Pass only when the pass message shows up in the output
run: build
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
